/* Makefile */
TOP := tb_gemm_host

all: run

obj_dir/V$(TOP): gemm_host.f *.sv
	verilator --binary --timing --assert -f gemm_host.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall gemm_host_pkg.sv gemm_csr.sv gemm_perf.sv \
		gemm_wb_slave.sv gemm_host_top.sv --top-module gemm_host_top

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* gemm_host.f */
gemm_host_pkg.sv
gemm_csr.sv
gemm_perf.sv
gemm_wb_slave.sv
gemm_host_top.sv
gemm_host_checker.sv
tb_gemm_host.sv

/* tb_gemm_host.sv */
/*
 * Testbench for the GEMM host control block
 * Directed tests over the Wishbone port: reset values, configuration
 * read-back, go/complete sequencing and performance counter gating.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_gemm_host;

  import gemm_host_pkg::*;

  localparam int ACK_TIMEOUT = 16;
  localparam int JOB_CYCLES  = 50;

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  perf_evt_t   evt;
  logic        test_cmp;
  gemm_cfg_t   cfg;
  logic        go;
  integer      seed;
  logic [31:0] shadow [16];
  logic [63:0] perf_exp [PERF_NUM];

  gemm_host_top dut (
    .clk        (clk),
    .i_rst_n    (rst_n),
    .i_wb       (wb_req),
    .o_wb       (wb_rsp),
    .i_evt      (evt),
    .i_test_cmp (test_cmp),
    .o_cfg      (cfg),
    .o_go       (go)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Drive the request and poll for ack one step past each edge
  task automatic wb_access(input logic we, input logic [5:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdata);
    int n;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    n = 0;
    do
    begin
      @(posedge clk);
      #1;
      n++;
    end
    while (!wb_rsp.ack && n < ACK_TIMEOUT);
    if (!wb_rsp.ack)
    begin
      $display("No Wishbone ack within %0d cycles at address 0x%02h", ACK_TIMEOUT, adr);
      $display("Test failures found");
      $fatal(1, "Bus timeout");
    end
    rdata = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_write(input logic [5:0] adr, input logic [31:0] wdat);
    logic [31:0] discard;
    wb_access(1'b1, adr, wdat, discard);
  endtask

  task automatic wb_read(input logic [5:0] adr, output logic [31:0] rdata);
    wb_access(1'b0, adr, 32'h0, rdata);
  endtask

  task automatic read_check(input logic [5:0] adr, input logic [31:0] exp);
    logic [31:0] rd;
    wb_read(adr, rd);
    check_value($sformatf("o_wb.dat @0x%02h", adr), 64'(rd), 64'(exp));
  endtask

  task automatic counter_check(input int idx, input logic [63:0] exp);
    logic [31:0] lo;
    logic [31:0] hi;
    wb_read(PERF_BASE + 6'(2 * idx), lo);
    wb_read(PERF_BASE + 6'(2 * idx + 1), hi);
    check_value($sformatf("o_wb.dat counter %0d", idx), {hi, lo}, exp);
  endtask

  task automatic cfg_check;
    check_value("o_cfg.src_a", cfg.src_a, {shadow[3], shadow[2]});
    check_value("o_cfg.src_b", cfg.src_b, {shadow[5], shadow[4]});
    check_value("o_cfg.dst_c", cfg.dst_c, {shadow[7], shadow[6]});
    check_value("o_cfg.num_blocks", 64'(cfg.num_blocks), 64'(shadow[8]));
    check_value("o_cfg.num_parts_a", 64'(cfg.num_parts_a), 64'(shadow[9]));
    check_value("o_cfg.num_parts_b", 64'(cfg.num_parts_b), 64'(shadow[10]));
    check_value("o_cfg.num_parts_c", 64'(cfg.num_parts_c), 64'(shadow[11]));
    check_value("o_cfg.rows_x_block", 64'(cfg.rows_x_block), 64'(shadow[12]));
    check_value("o_cfg.cols_x_block", 64'(cfg.cols_x_block), 64'(shadow[13]));
  endtask

  // Engine completion seen at one edge
  task automatic end_job;
    test_cmp = 1'b1;
    @(posedge clk);
    #1;
    test_cmp = 1'b0;
  endtask

  task automatic test_reset_values;
    check_value("o_wb.ack", 64'(wb_rsp.ack), 64'h0);
    check_value("o_go", 64'(go), 64'h0);
    read_check(ADDR_ID, GEMM_ID);
    read_check(ADDR_CTL, 32'h0);
    for (int a = 2; a < 14; a++)
    begin
      read_check(6'(a), 32'h0);
    end
    cfg_check();
    for (int i = 0; i < PERF_NUM; i++)
    begin
      counter_check(i, 64'h0);
    end
  endtask

  task automatic test_cfg_regs;
    logic [5:0] holes [4] = '{6'h0E, 6'h1F, 6'h2C, 6'h3F};
    for (int a = 2; a < 14; a++)
    begin
      shadow[a] = $random(seed);
      wb_write(6'(a), shadow[a]);
    end
    for (int a = 2; a < 14; a++)
    begin
      read_check(6'(a), shadow[a]);
    end
    cfg_check();
    // Unmapped words ignore writes and read zero
    for (int h = 0; h < 4; h++)
    begin
      wb_write(holes[h], $random(seed));
      read_check(holes[h], 32'h0);
    end
    cfg_check();
  endtask

  task automatic test_go_complete;
    wb_write(ADDR_CTL, 32'h1);
    check_value("o_go", 64'(go), 64'h1);
    @(posedge clk);
    #1;
    check_value("o_go", 64'(go), 64'h0);
    read_check(ADDR_CTL, 32'h1);
    // Go while running is dropped
    wb_write(ADDR_CTL, 32'h1);
    check_value("o_go", 64'(go), 64'h0);
    // Config writes still land while running
    shadow[8] = $random(seed);
    wb_write(ADDR_NUM_BLOCKS, shadow[8]);
    read_check(ADDR_NUM_BLOCKS, shadow[8]);
    end_job();
    read_check(ADDR_CTL, 32'h2);
    wb_write(ADDR_CTL, 32'h2);
    check_value("o_go", 64'(go), 64'h0);
    wb_write(ADDR_CTL, 32'h1);
    check_value("o_go", 64'(go), 64'h1);
    read_check(ADDR_CTL, 32'h1);
    end_job();
    read_check(ADDR_CTL, 32'h2);
  endtask

  task automatic test_event_counters;
    logic [31:0] r;
    for (int i = 0; i < PERF_NUM; i++)
    begin
      perf_exp[i] = 64'h0;
    end
    wb_write(ADDR_CTL, 32'h1);
    // Go cycle events fall under the clear
    evt = 5'h1F;
    for (int k = 0; k < JOB_CYCLES; k++)
    begin
      @(posedge clk);
      #1;
      r = $random(seed);
      evt = r[4:0];
      test_cmp = (k == JOB_CYCLES - 1);
      perf_exp[0] += 64'h1;
      perf_exp[1] += 64'(evt.rd_rsp);
      perf_exp[2] += 64'(evt.wr_rsp);
      perf_exp[3] += 64'(evt.rd_almfull);
      perf_exp[4] += 64'(evt.wr_almfull);
      perf_exp[5] += 64'(evt.pe_compute);
    end
    @(posedge clk);
    #1;
    test_cmp = 1'b0;
    evt = '0;
    read_check(ADDR_CTL, 32'h2);
    for (int i = 0; i < PERF_NUM; i++)
    begin
      counter_check(i, perf_exp[i]);
    end
  endtask

  task automatic test_gating_clear;
    logic [31:0] r;
    repeat (20)
    begin
      r = $random(seed);
      evt = r[4:0];
      @(posedge clk);
      #1;
    end
    evt = '0;
    for (int i = 0; i < PERF_NUM; i++)
    begin
      counter_check(i, perf_exp[i]);
    end
    // Completion in the go cycle leaves an empty count window
    wb_write(ADDR_CTL, 32'h1);
    evt = 5'h1F;
    end_job();
    evt = '0;
    read_check(ADDR_CTL, 32'h2);
    for (int i = 0; i < PERF_NUM; i++)
    begin
      counter_check(i, 64'h0);
    end
  endtask

  initial
  begin
    seed     = 86411;
    clk      = 1'b0;
    rst_n    = 1'b0;
    wb_req   = '0;
    evt      = '0;
    test_cmp = 1'b0;
    for (int a = 0; a < 16; a++)
    begin
      shadow[a] = 32'h0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    test_reset_values();
    test_cfg_regs();
    test_go_complete();
    test_event_counters();
    test_gating_clear();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* gemm_host_checker.sv */
/*
 * Bus and go timing checker for the GEMM host block
 * Flags a stretched, late or unrequested Wishbone ack and a go pulse
 * that is longer than one cycle or not tied to an ack.
 */

`timescale 1ns/10ps
`default_nettype none

module gemm_host_checker (
  input logic                   clk,
  input logic                   i_rst_n,
  input gemm_host_pkg::wb_req_t i_wb,
  input gemm_host_pkg::wb_rsp_t i_wb_rsp,
  input logic                   i_go
);

  // Ack lasts exactly one cycle
  ack_single: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_wb_rsp.ack |=> !i_wb_rsp.ack)
    else $error("Wishbone ack held for more than one cycle");

  ack_requested: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_wb_rsp.ack |-> $past(i_wb.cyc && i_wb.stb))
    else $error("Wishbone ack without cyc and stb in the previous cycle");

  // Ack comes on the clock after a fresh request
  ack_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_wb.cyc && i_wb.stb && !i_wb_rsp.ack) |=> i_wb_rsp.ack)
    else $error("Wishbone ack missing one cycle after a new request");

  go_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_go |=> !i_go)
    else $error("Go held for more than one cycle");

  // Go rises with the ack of the control write
  go_with_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_go |-> i_wb_rsp.ack)
    else $error("Go pulse outside a Wishbone ack cycle");

endmodule

bind gemm_host_top gemm_host_checker u_checker (
  .clk      (clk),
  .i_rst_n  (i_rst_n),
  .i_wb     (i_wb),
  .i_wb_rsp (o_wb),
  .i_go     (o_go)
);

`default_nettype wire

/* gemm_host_top.sv */
/*
 * GEMM host control top level
 * Wishbone slave in front of the configuration/control registers and
 * the performance counters of the matrix-multiply engine.
 */

`timescale 1ns/10ps
`default_nettype none

module gemm_host_top (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  gemm_host_pkg::wb_req_t   i_wb,
  output gemm_host_pkg::wb_rsp_t   o_wb,
  input  gemm_host_pkg::perf_evt_t i_evt,
  input  logic                     i_test_cmp,
  output gemm_host_pkg::gemm_cfg_t o_cfg,
  output logic                     o_go
);

  import gemm_host_pkg::*;

  reg_acc_t              csr_acc;
  logic [WB_DATA_W-1:0]  csr_rdata;
  logic [PERF_OFS_W-1:0] perf_offset;
  logic [WB_DATA_W-1:0]  perf_rdata;
  logic                  running;

  gemm_wb_slave u_wb_slave (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_wb          (i_wb),
    .o_wb          (o_wb),
    .o_csr_acc     (csr_acc),
    .i_csr_rdata   (csr_rdata),
    .o_perf_offset (perf_offset),
    .i_perf_rdata  (perf_rdata)
  );

  gemm_csr u_csr (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_acc      (csr_acc),
    .o_rdata    (csr_rdata),
    .i_test_cmp (i_test_cmp),
    .o_cfg      (o_cfg),
    .o_go       (o_go),
    .o_running  (running)
  );

  // Counters see the same go pulse that leaves for the engine
  gemm_perf u_perf (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_go      (o_go),
    .i_running (running),
    .i_evt     (i_evt),
    .i_offset  (perf_offset),
    .o_rdata   (perf_rdata)
  );

endmodule

`default_nettype wire

/* gemm_wb_slave.sv */
/*
 * Wishbone classic slave for the GEMM host block
 * Single-cycle acknowledge, address split into register and counter
 * regions, and a registered read word taken from the addressed region.
 */

`timescale 1ns/10ps
`default_nettype none

module gemm_wb_slave (
  input  logic                                 clk,
  input  logic                                 i_rst_n,
  input  gemm_host_pkg::wb_req_t               i_wb,
  output gemm_host_pkg::wb_rsp_t               o_wb,
  output gemm_host_pkg::reg_acc_t              o_csr_acc,
  input  logic [gemm_host_pkg::WB_DATA_W-1:0]  i_csr_rdata,
  output logic [gemm_host_pkg::PERF_OFS_W-1:0] o_perf_offset,
  input  logic [gemm_host_pkg::WB_DATA_W-1:0]  i_perf_rdata
);

  import gemm_host_pkg::*;

  logic                 ack_q;
  logic [WB_DATA_W-1:0] rdata_q;
  logic                 req_new;
  logic                 perf_sel;

  // A request not yet acknowledged
  assign req_new  = i_wb.cyc && i_wb.stb && !ack_q;
  assign perf_sel = (i_wb.adr >= PERF_BASE);

  always_comb
  begin
    o_csr_acc.we   = req_new && i_wb.we && !perf_sel;
    o_csr_acc.ofs  = i_wb.adr;
    o_csr_acc.wdat = i_wb.dat;
  end

  assign o_perf_offset = PERF_OFS_W'(i_wb.adr - PERF_BASE);

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      ack_q <= 1'b0;
    else
      ack_q <= req_new;
  end

  // Read word captured at the edge that raises ack
  always_ff @(posedge clk)
  begin
    if (req_new && !i_wb.we)
      rdata_q <= perf_sel ? i_perf_rdata : i_csr_rdata;
  end

  assign o_wb.ack = ack_q;
  assign o_wb.dat = rdata_q;

endmodule

`default_nettype wire

/* gemm_perf.sv */
/*
 * GEMM performance counters
 * Six 64-bit counters (clocks and five engine events), cleared by go
 * and advanced only while a job runs. Read as lo/hi word pairs.
 */

`timescale 1ns/10ps
`default_nettype none

module gemm_perf (
  input  logic                                 clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_go,
  input  logic                                 i_running,
  input  gemm_host_pkg::perf_evt_t             i_evt,
  input  logic [gemm_host_pkg::PERF_OFS_W-1:0] i_offset,
  output logic [gemm_host_pkg::WB_DATA_W-1:0]  o_rdata
);

  import gemm_host_pkg::*;

  logic [CNT_W-1:0]        cnt_q [PERF_NUM];
  logic [PERF_NUM-1:0]     inc;
  logic [PERF_OFS_W-2:0]   idx;
  logic [CNT_W-1:0]        sel_cnt;

  // Bit order follows the address map, clock counter in bit 0
  assign inc = {i_evt.pe_compute,
                i_evt.wr_almfull,
                i_evt.rd_almfull,
                i_evt.wr_rsp,
                i_evt.rd_rsp,
                1'b1};

  always_ff @(posedge clk)
  begin
    if (!i_rst_n || i_go)
    begin
      for (int i = 0; i < PERF_NUM; i++)
      begin
        cnt_q[i] <= '0;
      end
    end
    else if (i_running)
    begin
      for (int i = 0; i < PERF_NUM; i++)
      begin
        cnt_q[i] <= cnt_q[i] + CNT_W'(inc[i]);
      end
    end
  end

  // Word pair index, then pick the half
  assign idx = i_offset[PERF_OFS_W-1:1];

  always_comb
  begin
    sel_cnt = '0;
    if (int'(idx) < PERF_NUM)
    begin
      sel_cnt = cnt_q[idx[PERF_IDX_W-1:0]];
    end
    o_rdata = i_offset[0] ? sel_cnt[CNT_W-1:WB_DATA_W] : sel_cnt[WB_DATA_W-1:0];
  end

endmodule

`default_nettype wire

/* gemm_csr.sv */
/*
 * GEMM configuration and control registers
 * Holds the job addresses and counts, returns them with the ID word,
 * and runs the go / running / complete sequence that a control write
 * starts and the engine completion ends.
 */

`timescale 1ns/10ps
`default_nettype none

module gemm_csr (
  input  logic                                clk,
  input  logic                                i_rst_n,
  input  gemm_host_pkg::reg_acc_t             i_acc,
  output logic [gemm_host_pkg::WB_DATA_W-1:0] o_rdata,
  input  logic                                i_test_cmp,
  output gemm_host_pkg::gemm_cfg_t            o_cfg,
  output logic                                o_go,
  output logic                                o_running
);

  import gemm_host_pkg::*;

  gemm_cfg_t cfg_q;
  logic      go_q;
  logic      running_q;
  logic      complete_q;
  logic      go_wr;

  // Go is honoured only while idle
  assign go_wr = i_acc.we && (i_acc.ofs == ADDR_CTL) && i_acc.wdat[0] && !running_q;

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      cfg_q <= '0;
    end
    else if (i_acc.we)
    begin
      case (i_acc.ofs)
        ADDR_SRC_A_LO:     cfg_q.src_a[31:0]  <= i_acc.wdat;
        ADDR_SRC_A_HI:     cfg_q.src_a[63:32] <= i_acc.wdat;
        ADDR_SRC_B_LO:     cfg_q.src_b[31:0]  <= i_acc.wdat;
        ADDR_SRC_B_HI:     cfg_q.src_b[63:32] <= i_acc.wdat;
        ADDR_DST_C_LO:     cfg_q.dst_c[31:0]  <= i_acc.wdat;
        ADDR_DST_C_HI:     cfg_q.dst_c[63:32] <= i_acc.wdat;
        ADDR_NUM_BLOCKS:   cfg_q.num_blocks   <= i_acc.wdat;
        ADDR_NUM_PARTS_A:  cfg_q.num_parts_a  <= i_acc.wdat;
        ADDR_NUM_PARTS_B:  cfg_q.num_parts_b  <= i_acc.wdat;
        ADDR_NUM_PARTS_C:  cfg_q.num_parts_c  <= i_acc.wdat;
        ADDR_ROWS_X_BLOCK: cfg_q.rows_x_block <= i_acc.wdat;
        ADDR_COLS_X_BLOCK: cfg_q.cols_x_block <= i_acc.wdat;
        default:           cfg_q              <= cfg_q;
      endcase
    end
  end

  // Job state: go starts it, engine completion ends it
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      go_q       <= 1'b0;
      running_q  <= 1'b0;
      complete_q <= 1'b0;
    end
    else
    begin
      go_q <= go_wr;
      if (go_wr)
      begin
        running_q  <= 1'b1;
        complete_q <= 1'b0;
      end
      else if (running_q && i_test_cmp)
      begin
        running_q  <= 1'b0;
        complete_q <= 1'b1;
      end
    end
  end

  // Read-back for the offset currently on the bus
  always_comb
  begin
    o_rdata = '0;
    case (i_acc.ofs)
      ADDR_CTL:          o_rdata = {{(WB_DATA_W-2){1'b0}}, complete_q, running_q};
      ADDR_ID:           o_rdata = GEMM_ID;
      ADDR_SRC_A_LO:     o_rdata = cfg_q.src_a[31:0];
      ADDR_SRC_A_HI:     o_rdata = cfg_q.src_a[63:32];
      ADDR_SRC_B_LO:     o_rdata = cfg_q.src_b[31:0];
      ADDR_SRC_B_HI:     o_rdata = cfg_q.src_b[63:32];
      ADDR_DST_C_LO:     o_rdata = cfg_q.dst_c[31:0];
      ADDR_DST_C_HI:     o_rdata = cfg_q.dst_c[63:32];
      ADDR_NUM_BLOCKS:   o_rdata = cfg_q.num_blocks;
      ADDR_NUM_PARTS_A:  o_rdata = cfg_q.num_parts_a;
      ADDR_NUM_PARTS_B:  o_rdata = cfg_q.num_parts_b;
      ADDR_NUM_PARTS_C:  o_rdata = cfg_q.num_parts_c;
      ADDR_ROWS_X_BLOCK: o_rdata = cfg_q.rows_x_block;
      ADDR_COLS_X_BLOCK: o_rdata = cfg_q.cols_x_block;
      default:           o_rdata = '0;
    endcase
  end

  assign o_cfg     = cfg_q;
  assign o_go      = go_q;
  assign o_running = running_q;

endmodule

`default_nettype wire

/* gemm_host_pkg.sv */
/*
 * GEMM host control package
 * Bus widths, the register address map, the ID word and the packed
 * structs shared by the Wishbone slave, the CSR block and the
 * performance counter block.
 */

`default_nettype none

package gemm_host_pkg;

  // Bus and counter widths
  localparam int WB_DATA_W  = 32;
  localparam int WB_ADDR_W  = 6;
  localparam int CNT_W      = 64;

  localparam logic [WB_DATA_W-1:0] GEMM_ID = 32'h4745_4D4D;

  // Word address map of the register block
  localparam logic [WB_ADDR_W-1:0] ADDR_CTL          = 6'h00;
  localparam logic [WB_ADDR_W-1:0] ADDR_ID           = 6'h01;
  localparam logic [WB_ADDR_W-1:0] ADDR_SRC_A_LO     = 6'h02;
  localparam logic [WB_ADDR_W-1:0] ADDR_SRC_A_HI     = 6'h03;
  localparam logic [WB_ADDR_W-1:0] ADDR_SRC_B_LO     = 6'h04;
  localparam logic [WB_ADDR_W-1:0] ADDR_SRC_B_HI     = 6'h05;
  localparam logic [WB_ADDR_W-1:0] ADDR_DST_C_LO     = 6'h06;
  localparam logic [WB_ADDR_W-1:0] ADDR_DST_C_HI     = 6'h07;
  localparam logic [WB_ADDR_W-1:0] ADDR_NUM_BLOCKS   = 6'h08;
  localparam logic [WB_ADDR_W-1:0] ADDR_NUM_PARTS_A  = 6'h09;
  localparam logic [WB_ADDR_W-1:0] ADDR_NUM_PARTS_B  = 6'h0A;
  localparam logic [WB_ADDR_W-1:0] ADDR_NUM_PARTS_C  = 6'h0B;
  localparam logic [WB_ADDR_W-1:0] ADDR_ROWS_X_BLOCK = 6'h0C;
  localparam logic [WB_ADDR_W-1:0] ADDR_COLS_X_BLOCK = 6'h0D;

  // Counter region: lo/hi word pairs, clocks first
  localparam logic [WB_ADDR_W-1:0] PERF_BASE = 6'h20;
  localparam int PERF_NUM   = 6;
  localparam int PERF_OFS_W = 5;
  localparam int PERF_IDX_W = $clog2(PERF_NUM);

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [WB_DATA_W-1:0] dat;
  } wb_rsp_t;

  // One decoded access as seen by a register block
  typedef struct packed {
    logic                 we;
    logic [WB_ADDR_W-1:0] ofs;
    logic [WB_DATA_W-1:0] wdat;
  } reg_acc_t;

  typedef struct packed {
    logic [63:0] src_a;
    logic [63:0] src_b;
    logic [63:0] dst_c;
    logic [31:0] num_blocks;
    logic [31:0] num_parts_a;
    logic [31:0] num_parts_b;
    logic [31:0] num_parts_c;
    logic [31:0] rows_x_block;
    logic [31:0] cols_x_block;
  } gemm_cfg_t;

  // Per-cycle engine events
  typedef struct packed {
    logic rd_rsp;
    logic wr_rsp;
    logic rd_almfull;
    logic wr_almfull;
    logic pe_compute;
  } perf_evt_t;

endpackage

`default_nettype wire
